/* tetris_ctrl.f */
logic/tetris_pkg.sv
logic/uart_rx.sv
logic/btn_debounce.sv
logic/cmd_decoder.sv
logic/cmd_queue.sv
logic/piece_mover.sv
logic/tetris_ctrl.sv
verif/tetris_ctrl_chk.sv
verif/tetris_ctrl_tb.sv

/* Bender.yml */
package:
  name: tetris_ctrl

sources:
  - logic/tetris_pkg.sv
  - logic/uart_rx.sv
  - logic/btn_debounce.sv
  - logic/cmd_decoder.sv
  - logic/cmd_queue.sv
  - logic/piece_mover.sv
  - logic/tetris_ctrl.sv
  - target: test
    files:
      - verif/tetris_ctrl_chk.sv
      - verif/tetris_ctrl_tb.sv

/* verif/tetris_ctrl_tb.sv */
`timescale 1ns/100ps

module tetris_ctrl_tb;

  localparam int apply_timeout = 400;
  localparam int quiet_cycles  = 60;

  logic               clk;
  logic               reset_n;
  logic               uart_rx_line;
  logic [3:0]         usr_btn;
  tetris_pkg::state_t state;
  tetris_pkg::piece_t piece;
  tetris_pkg::rot_t   rot;
  tetris_pkg::cmd_t   applied;
  logic               applied_valid;
  logic               dropped;

  tetris_pkg::piece_t model_piece;
  tetris_pkg::rot_t   model_rot;
  tetris_pkg::cmd_t   got_cmd [$];
  tetris_pkg::piece_t got_piece [$];
  tetris_pkg::rot_t   got_rot [$];
  int                 drop_count;
  int                 error_count;

  logic [7:0] keys [15] = '{"A", "a", "D", "d", "W", "w", "S", "s", " ",
                            "C", "c", "X", "x", "Z", "z"};
  tetris_pkg::cmd_t key_cmds [15] = '{tetris_pkg::LEFT, tetris_pkg::LEFT,
    tetris_pkg::RIGHT, tetris_pkg::RIGHT, tetris_pkg::DOWN, tetris_pkg::DOWN,
    tetris_pkg::DROP, tetris_pkg::DROP, tetris_pkg::DROP, tetris_pkg::HOLD,
    tetris_pkg::HOLD, tetris_pkg::ROTATE, tetris_pkg::ROTATE,
    tetris_pkg::ROTATE_REV, tetris_pkg::ROTATE_REV};
  tetris_pkg::cmd_t btn_cmds [4] = '{tetris_pkg::RIGHT, tetris_pkg::DOWN,
    tetris_pkg::LEFT, tetris_pkg::ROTATE};

  tetris_ctrl i_dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .uart_rx_line  (uart_rx_line),
    .usr_btn       (usr_btn),
    .state         (state),
    .piece         (piece),
    .rot           (rot),
    .applied       (applied),
    .applied_valid (applied_valid),
    .dropped       (dropped)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) begin // mid cycle, all registered outputs are settled
    if (applied_valid === 1'b1) begin
      got_cmd.push_back(applied);
      got_piece.push_back(piece);
      got_rot.push_back(rot);
    end
    if (dropped === 1'b1) drop_count++;
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_cmd(input tetris_pkg::cmd_t got, input tetris_pkg::cmd_t exp);
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: applied got %s expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_piece(input tetris_pkg::piece_t got, input tetris_pkg::piece_t exp);
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: piece (col,row,held) got %0d,%0d,%0b expected %0d,%0d,%0b",
               $time, got.col, got.row, got.held, exp.col, exp.row, exp.held);
    end
  endtask

  task automatic check_rot(input tetris_pkg::rot_t got, input tetris_pkg::rot_t exp);
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: rot got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  // movement rules of the game applied to the model piece
  task automatic model_apply(input tetris_pkg::cmd_t c);
    case (c)
      tetris_pkg::LEFT:       if (model_piece.col != 0) model_piece.col--;
      tetris_pkg::RIGHT:      if (model_piece.col != tetris_pkg::board_cols - 1) model_piece.col++;
      tetris_pkg::DOWN:       if (model_piece.row != tetris_pkg::board_rows - 1) model_piece.row++;
      tetris_pkg::DROP:       model_piece.row = 5'(tetris_pkg::board_rows - 1);
      tetris_pkg::ROTATE:     model_rot = model_rot + 2'd1;
      tetris_pkg::ROTATE_REV: model_rot = model_rot - 2'd1;
      tetris_pkg::HOLD: begin
        model_piece.held = !model_piece.held;
        model_piece.col  = 4'(tetris_pkg::spawn_col);
        model_piece.row  = 5'(tetris_pkg::spawn_row);
        model_rot        = '0;
      end
      default: ;
    endcase
  endtask

  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0}; // stop, data lsb first, start
    for (int i = 0; i < 10; i++) begin
      uart_rx_line = frame[i];
      repeat (tetris_pkg::clks_per_bit) next_cycle();
    end
  endtask

  task automatic press_button(input int idx, input int hold);
    usr_btn[idx] = 1'b1;
    repeat (hold) next_cycle();
    usr_btn[idx] = 1'b0;
    repeat (tetris_pkg::debounce_cycles + 4) next_cycle(); // release must settle too
  endtask

  task automatic expect_applied(input tetris_pkg::cmd_t exp);
    int waited;
    waited = 0;
    while (got_cmd.size() == 0 && waited < apply_timeout) begin
      next_cycle();
      waited++;
    end
    if (got_cmd.size() == 0) begin
      error_count++;
      $display("error at %0t: no command applied within %0d cycles, expected %s",
               $time, apply_timeout, exp.name());
    end else begin
      model_apply(exp);
      check_cmd(got_cmd.pop_front(), exp);
      check_piece(got_piece.pop_front(), model_piece);
      check_rot(got_rot.pop_front(), model_rot);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) next_cycle();
    check_count("unexpected applied commands", got_cmd.size(), 0);
    got_cmd.delete();
    got_piece.delete();
    got_rot.delete();
  endtask

  task automatic test_reset();
    check_piece(piece, model_piece);
    check_rot(rot, model_rot);
    check_bit("applied_valid", applied_valid, 1'b0);
    check_bit("dropped", dropped, 1'b0);
  endtask

  task automatic test_uart_keys();
    state = tetris_pkg::WAIT;
    foreach (keys[i]) begin
      send_byte(keys[i]);
      expect_applied(key_cmds[i]);
    end
    send_byte("q"); // not mapped to any command
    expect_quiet(quiet_cycles);
  endtask

  task automatic test_buttons();
    state = tetris_pkg::WAIT;
    for (int b = 0; b < 4; b++) begin
      press_button(b, tetris_pkg::debounce_cycles + 4);
      expect_applied(btn_cmds[b]);
      expect_quiet(quiet_cycles);
    end
    press_button(3, 6 * tetris_pkg::debounce_cycles); // a long hold must not repeat
    expect_applied(btn_cmds[3]);
    expect_quiet(quiet_cycles);
  endtask

  task automatic test_border();
    logic [7:0]       key;
    tetris_pkg::cmd_t key_cmd;
    state = tetris_pkg::WAIT;
    repeat (2 * tetris_pkg::board_cols + 4) begin
      if ($urandom % 2 == 0) begin
        key     = "a";
        key_cmd = tetris_pkg::LEFT;
      end else begin
        key     = "d";
        key_cmd = tetris_pkg::RIGHT;
      end
      send_byte(key);
      expect_applied(key_cmd);
    end
    repeat (tetris_pkg::board_cols + 1) begin
      send_byte("a");
      expect_applied(tetris_pkg::LEFT);
    end
    check_count("piece.col", piece.col, 0);
    repeat (tetris_pkg::board_cols + 1) begin
      send_byte("d");
      expect_applied(tetris_pkg::RIGHT);
    end
    check_count("piece.col", piece.col, tetris_pkg::board_cols - 1);
    send_byte("s");
    expect_applied(tetris_pkg::DROP);
    check_count("piece.row", piece.row, tetris_pkg::board_rows - 1);
    send_byte("c");
    expect_applied(tetris_pkg::HOLD);
  endtask

  task automatic test_queue();
    tetris_pkg::cmd_t expected [$];
    int idx;
    state = tetris_pkg::PLAY;
    drop_count = 0;
    for (int i = 0; i < tetris_pkg::queue_depth + 2; i++) begin
      idx = $urandom % 15;
      send_byte(keys[idx]);
      if (i < tetris_pkg::queue_depth) expected.push_back(key_cmds[idx]);
    end
    check_count("commands applied while playing", got_cmd.size(), 0);
    check_count("dropped pulses", drop_count, 2);
    state = tetris_pkg::WAIT;
    foreach (expected[i]) expect_applied(expected[i]);
    expect_quiet(quiet_cycles);
  endtask

  initial begin
    void'($urandom(32'h5091_9a1b));
    error_count  = 0;
    drop_count   = 0;
    reset_n      = 1'b0;
    uart_rx_line = 1'b1;
    usr_btn      = 4'b0000;
    state        = tetris_pkg::IDLE;
    model_piece  = '{col: 4'(tetris_pkg::spawn_col), row: 5'(tetris_pkg::spawn_row), held: 1'b0};
    model_rot    = '0;
    repeat (3) next_cycle();
    reset_n = 1'b1;
    next_cycle();
    test_reset();
    test_uart_keys();
    test_buttons();
    test_border();
    test_queue();
    $display("checks finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verif/tetris_ctrl_chk.sv */
`timescale 1ns/100ps

module tetris_ctrl_chk #(
  parameter bit queue_side = 1'b1 // queue rules, otherwise the board rule of the mover
) (
  input logic                                clk,
  input logic                                reset_n,
  input logic                                pop,
  input logic                                not_empty,
  input logic [tetris_pkg::queue_ptr_bits:0] count,
  input tetris_pkg::piece_t                  piece
);

  if (queue_side) begin : g_queue
    a_no_pop_when_empty: assert property (
      @(posedge clk) disable iff (!reset_n) pop |-> not_empty
    ) else $error("pop while the command queue is empty");

    a_count_in_range: assert property (
      @(posedge clk) disable iff (!reset_n) count <= tetris_pkg::queue_depth
    ) else $error("queue count above its depth");
  end else begin : g_mover
    a_piece_on_board: assert property (
      @(posedge clk) disable iff (!reset_n)
        (piece.col < tetris_pkg::board_cols) && (piece.row < tetris_pkg::board_rows)
    ) else $error("piece left the board");
  end

endmodule

bind cmd_queue tetris_ctrl_chk #(
  .queue_side (1'b1)
) i_queue_chk (
  .clk       (clk),
  .reset_n   (reset_n),
  .pop       (pop),
  .not_empty (not_empty),
  .count     (count),
  .piece     ('0)
);

bind piece_mover tetris_ctrl_chk #(
  .queue_side (1'b0)
) i_mover_chk (
  .clk       (clk),
  .reset_n   (reset_n),
  .pop       (pop),
  .not_empty (not_empty),
  .count     ('0),
  .piece     (piece)
);

/* logic/tetris_ctrl.sv */
`timescale 1ns/100ps

module tetris_ctrl (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               uart_rx_line,
  input  logic [3:0]         usr_btn,
  input  tetris_pkg::state_t state,
  output tetris_pkg::piece_t piece,
  output tetris_pkg::rot_t   rot,
  output tetris_pkg::cmd_t   applied,
  output logic               applied_valid,
  output logic               dropped
);

  logic [7:0]       rx_byte;
  logic             rx_valid;
  logic [3:0]       btn_press;
  tetris_pkg::cmd_t cmd;
  logic             cmd_valid;
  tetris_pkg::cmd_t head;
  logic             not_empty;
  logic             pop;

  uart_rx i_uart_rx (
    .clk      (clk),
    .reset_n  (reset_n),
    .line     (uart_rx_line),
    .byte_out (rx_byte),
    .valid    (rx_valid)
  );

  for (genvar gi = 0; gi < 4; gi++) begin : g_btn
    btn_debounce i_btn_debounce (
      .clk     (clk),
      .reset_n (reset_n),
      .btn     (usr_btn[gi]),
      .press   (btn_press[gi])
    );
  end

  cmd_decoder i_cmd_decoder (
    .clk       (clk),
    .reset_n   (reset_n),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .btn_press (btn_press),
    .cmd       (cmd),
    .cmd_valid (cmd_valid)
  );

  cmd_queue i_cmd_queue (
    .clk       (clk),
    .reset_n   (reset_n),
    .push      (cmd_valid),
    .push_cmd  (cmd),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .dropped   (dropped)
  );

  piece_mover i_piece_mover (
    .clk           (clk),
    .reset_n       (reset_n),
    .state         (state),
    .head          (head),
    .not_empty     (not_empty),
    .pop           (pop),
    .piece         (piece),
    .rot           (rot),
    .applied       (applied),
    .applied_valid (applied_valid)
  );

endmodule

/* logic/piece_mover.sv */
`timescale 1ns/100ps

module piece_mover (
  input  logic                clk,
  input  logic                reset_n,
  input  tetris_pkg::state_t  state,
  input  tetris_pkg::cmd_t    head,
  input  logic                not_empty,
  output logic                pop,
  output tetris_pkg::piece_t  piece,
  output tetris_pkg::rot_t    rot,
  output tetris_pkg::cmd_t    applied,
  output logic                applied_valid
);

  logic at_left;
  logic at_right;
  logic at_bottom;

  // the game only lets the piece move while it waits for the next tick
  assign pop = (state == tetris_pkg::WAIT) && not_empty;

  assign at_left   = (piece.col == '0);
  assign at_right  = (piece.col == tetris_pkg::board_cols - 1);
  assign at_bottom = (piece.row == tetris_pkg::board_rows - 1);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      piece.col     <= 4'(tetris_pkg::spawn_col);
      piece.row     <= 5'(tetris_pkg::spawn_row);
      piece.held    <= 1'b0;
      rot           <= '0;
      applied_valid <= 1'b0;
    end else begin
      applied_valid <= pop; // clamped moves are still reported
      if (pop) begin
        case (head)
          tetris_pkg::LEFT: begin
            if (!at_left) piece.col <= piece.col - 1'b1;
          end
          tetris_pkg::RIGHT: begin
            if (!at_right) piece.col <= piece.col + 1'b1;
          end
          tetris_pkg::DOWN: begin
            if (!at_bottom) piece.row <= piece.row + 1'b1;
          end
          tetris_pkg::DROP: begin
            piece.row <= 5'(tetris_pkg::board_rows - 1); // no stack yet, so it lands on the floor
          end
          tetris_pkg::HOLD: begin
            piece.held <= !piece.held;
            piece.col  <= 4'(tetris_pkg::spawn_col);
            piece.row  <= 5'(tetris_pkg::spawn_row);
            rot        <= '0; // swapped piece comes back unrotated
          end
          tetris_pkg::ROTATE: begin
            rot <= rot + 1'b1;
          end
          tetris_pkg::ROTATE_REV: begin
            rot <= rot - 1'b1;
          end
          default: begin
            piece <= piece;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      applied <= head;
    end
  end

endmodule

/* logic/cmd_queue.sv */
`timescale 1ns/100ps

module cmd_queue (
  input  logic             clk,
  input  logic             reset_n,
  input  logic             push,
  input  tetris_pkg::cmd_t push_cmd,
  input  logic             pop,
  output tetris_pkg::cmd_t head,
  output logic             not_empty,
  output logic             dropped
);

  tetris_pkg::cmd_t                      mem [tetris_pkg::queue_depth];
  logic [tetris_pkg::queue_ptr_bits-1:0] wr_ptr;
  logic [tetris_pkg::queue_ptr_bits-1:0] rd_ptr;
  logic [tetris_pkg::queue_ptr_bits:0]   count;
  logic                                  full;
  logic                                  do_push;
  logic                                  do_pop;

  assign full      = (count == tetris_pkg::queue_depth);
  assign not_empty = (count != '0);
  assign do_push   = push && !full; // a full queue ignores the push even if popped now
  assign do_pop    = pop && not_empty;
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      dropped <= 1'b0;
    end else begin
      dropped <= push && full;
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // depth is a power of two so pointers wrap by themselves
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

endmodule

/* logic/cmd_decoder.sv */
`timescale 1ns/100ps

module cmd_decoder (
  input  logic             clk,
  input  logic             reset_n,
  input  logic [7:0]       rx_byte,
  input  logic             rx_valid,
  input  logic [3:0]       btn_press,
  output tetris_pkg::cmd_t cmd,
  output logic             cmd_valid
);

  tetris_pkg::cmd_t byte_cmd;
  tetris_pkg::cmd_t next_cmd;

  always_comb begin
    case (rx_byte)
      "A", "a":      byte_cmd = tetris_pkg::LEFT;
      "D", "d":      byte_cmd = tetris_pkg::RIGHT;
      "W", "w":      byte_cmd = tetris_pkg::DOWN;
      "S", "s", " ": byte_cmd = tetris_pkg::DROP;
      "C", "c":      byte_cmd = tetris_pkg::HOLD;
      "X", "x":      byte_cmd = tetris_pkg::ROTATE;
      "Z", "z":      byte_cmd = tetris_pkg::ROTATE_REV;
      default:       byte_cmd = tetris_pkg::NONE;
    endcase
  end

  // keyboard wins, then the lowest button; the rest of the cycle is lost
  always_comb begin
    next_cmd = tetris_pkg::NONE;
    if (rx_valid && byte_cmd != tetris_pkg::NONE) begin
      next_cmd = byte_cmd;
    end else if (btn_press[0]) begin
      next_cmd = tetris_pkg::RIGHT;
    end else if (btn_press[1]) begin
      next_cmd = tetris_pkg::DOWN;
    end else if (btn_press[2]) begin
      next_cmd = tetris_pkg::LEFT;
    end else if (btn_press[3]) begin
      next_cmd = tetris_pkg::ROTATE;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= (next_cmd != tetris_pkg::NONE);
    end
  end

  always_ff @(posedge clk) begin
    cmd <= next_cmd;
  end

endmodule

/* logic/btn_debounce.sv */
`timescale 1ns/100ps

module btn_debounce (
  input  logic clk,
  input  logic reset_n,
  input  logic btn,
  output logic press
);

  logic [1:0]                               btn_sync;
  logic                                     level;
  logic [tetris_pkg::debounce_cnt_bits-1:0] stable_cnt;
  logic                                     differs;

  assign differs = (btn_sync[1] != level);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      btn_sync   <= 2'b00;
      level      <= 1'b0;
      stable_cnt <= '0;
      press      <= 1'b0;
    end else begin
      btn_sync <= {btn_sync[0], btn};
      press    <= 1'b0;
      if (differs) begin
        if (stable_cnt == tetris_pkg::debounce_cycles - 1) begin
          level      <= btn_sync[1];
          stable_cnt <= '0;
          press      <= btn_sync[1]; // only a rising flip counts as a press
        end else begin
          stable_cnt <= stable_cnt + 1'b1;
        end
      end else begin
        stable_cnt <= '0; // any bounce back restarts the count
      end
    end
  end

endmodule

/* logic/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       line,
  output logic [7:0] byte_out,
  output logic       valid
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t                               rx_state;
  logic [1:0]                              line_sync;
  logic                                    line_s;
  logic [tetris_pkg::baud_cnt_bits-1:0]    baud_cnt;
  logic [2:0]                              bit_idx;
  logic [7:0]                              shift;
  logic                                    bit_end;

  assign line_s  = line_sync[1];
  assign bit_end = (baud_cnt == tetris_pkg::clks_per_bit - 1);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      line_sync <= 2'b11; // idle line is high
      rx_state  <= rx_idle;
      baud_cnt  <= '0;
      bit_idx   <= '0;
      valid     <= 1'b0;
    end else begin
      line_sync <= {line_sync[0], line};
      valid     <= 1'b0;
      case (rx_state)
        rx_idle: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (!line_s) rx_state <= rx_start;
        end
        rx_start: begin
          if (baud_cnt == tetris_pkg::clks_per_bit / 2 - 1) begin
            baud_cnt <= '0;
            rx_state <= line_s ? rx_idle : rx_data; // a short glitch is not a start bit
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_data: begin
          if (bit_end) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) rx_state <= rx_stop;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        rx_stop: begin
          if (bit_end) begin
            baud_cnt <= '0;
            valid    <= line_s; // framing error gives no strobe
            rx_state <= rx_idle;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: rx_state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rx_state == rx_data && bit_end) begin
      shift <= {line_s, shift[7:1]}; // lsb arrives first
    end
  end

  assign byte_out = shift;

endmodule

/* logic/tetris_pkg.sv */
package tetris_pkg;

  // game commands, NONE marks an empty slot or an unmapped key
  typedef enum logic [2:0] {
    NONE,
    LEFT,
    RIGHT,
    DOWN,
    DROP,
    HOLD,
    ROTATE,
    ROTATE_REV
  } cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    PLAY,
    WAIT
  } state_t;

  typedef struct packed {
    logic [3:0] col; // 0 to board_cols-1
    logic [4:0] row; // 0 at the top
    logic       held;
  } piece_t;

  typedef logic [1:0] rot_t; // quarter turns, wraps 3 to 0

  localparam int clks_per_bit    = 16;
  localparam int debounce_cycles = 8;
  localparam int queue_depth     = 8;
  localparam int board_cols      = 10;
  localparam int board_rows      = 20;
  localparam int spawn_col       = 4;
  localparam int spawn_row       = 0;

  localparam int baud_cnt_bits     = $clog2(clks_per_bit);
  localparam int debounce_cnt_bits = $clog2(debounce_cycles);
  localparam int queue_ptr_bits    = $clog2(queue_depth);

endpackage
